// ==== bench/tb_capture.sv ====
`timescale 1ns/1ps

`include "capture_cfg.svh"

module tb_capture;

    logic                  img_dclk;
    logic                  rst_n;
    logic                  img_fv;
    logic                  img_lv;
    logic [`CAP_PIX_W-1:0] img_d;
    logic                  res_ready;
    logic                  res_valid;
    logic [`CAP_IDX_W-1:0] res_index;
    logic [`CAP_LEN_W-1:0] res_len;
    logic [`CAP_SUM_W-1:0] res_sum;
    logic [`CAP_PIX_W-1:0] res_max;
    logic                  overflow;
    logic [15:0]           drop_count;

    // pixels of the line being driven
    logic [`CAP_PIX_W-1:0] line_pix [$];
    // expected results as {index, len, sum, max}
    logic [58:0]           exp_q [$];
    logic [58:0]           exp_word;
    logic [16:0]           lfsr;
    // compare against exp_q when set, else only bound the length
    logic                  strict;
    logic [`CAP_LEN_W-1:0] cur_width;
    // res_ready mode
    // 0 always high
    // 1 each result stalled 4 cycles
    // 2 held low
    int                    ready_mode;
    int                    stall_cnt;
    int                    errors;
    int                    results;

    capture_top uut (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .img_fv     (img_fv),
        .img_lv     (img_lv),
        .img_d      (img_d),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_index  (res_index),
        .res_len    (res_len),
        .res_sum    (res_sum),
        .res_max    (res_max),
        .overflow   (overflow),
        .drop_count (drop_count)
    );

    always #20 img_dclk = ~img_dclk;

    // x^17 + x^14 + 1 with the new bit entering at the bottom
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one lfsr step per pixel bit
    task automatic next_pixel(output logic [`CAP_PIX_W-1:0] pix);
        int b;
        pix = '0;
        for (b = 0; b < `CAP_PIX_W; b++) begin
            lfsr = lfsr_step(lfsr);
            pix  = {pix[`CAP_PIX_W-2:0], lfsr[0]};
        end
    endtask

    // expected result of the line held in line_pix
    function automatic logic [58:0] line_expect(input int row);
        logic [`CAP_SUM_W-1:0] sum;
        logic [`CAP_PIX_W-1:0] mx;
        sum = '0;
        mx  = '0;
        foreach (line_pix[i]) begin
            sum += `CAP_SUM_W'(line_pix[i]);
            if (line_pix[i] > mx) begin
                mx = line_pix[i];
            end
        end
        return {12'(row), 11'(line_pix.size()), sum, mx};
    endfunction

    // cycles from fv rise to fv fall
    // each line adds lv low and 6 blank cycles
    function automatic int frame_cycles(input int width, input int height);
        return 8 + height * (width + 7);
    endfunction

    task automatic send_frame(input int width, input int height);
        int row;
        int col;
        logic [`CAP_PIX_W-1:0] pix;
        @(posedge img_dclk);
        img_fv <= 1'b1;
        repeat (6) @(posedge img_dclk);
        for (row = 0; row < height; row++) begin
            line_pix.delete();
            for (col = 0; col < width; col++) begin
                next_pixel(pix);
                @(posedge img_dclk);
                img_lv <= 1'b1;
                img_d  <= pix;
                line_pix.push_back(pix);
            end
            @(posedge img_dclk);
            img_lv <= 1'b0;
            img_d  <= '0;
            if (strict) begin
                exp_q.push_back(line_expect(row));
            end
            repeat (6) @(posedge img_dclk);
        end
        @(posedge img_dclk);
        img_fv <= 1'b0;
    endtask

    // every expected line has been reported
    task automatic drain_expected();
        while (exp_q.size() != 0) begin
            @(posedge img_dclk);
        end
    endtask

    // wait for 20 cycles without a result
    task automatic wait_results_idle();
        int idle;
        idle = 0;
        while (idle < 20) begin
            @(posedge img_dclk);
            if (res_valid) begin
                idle = 0;
            end else begin
                idle++;
            end
        end
    endtask

    // res_ready per phase
    always @(posedge img_dclk) begin
        if (ready_mode == 0) begin
            res_ready <= 1'b1;
        end else if (ready_mode == 1 && res_valid && !res_ready) begin
            // take the result after 4 edges of stall
            if (stall_cnt == 3) begin
                res_ready <= 1'b1;
                stall_cnt <= 0;
            end else begin
                stall_cnt <= stall_cnt + 1;
            end
        end else begin
            res_ready <= 1'b0;
        end
    end

    // scoreboard on every accepted result
    always @(posedge img_dclk) begin
        if (rst_n && res_valid && res_ready) begin
            results++;
            if (!strict) begin
                if (res_len > cur_width) begin
                    $display("a result reports %0d pixels but only %0d were driven in a line",
                             res_len, cur_width);
                    errors++;
                end
            end else if (exp_q.size() == 0) begin
                $display("a result arrived at %0t while no line was pending", $time);
                errors++;
            end else begin
                exp_word = exp_q.pop_front();
                if (res_index !== exp_word[58:47]) begin
                    $display("Error at %0t: index %0d, expected %0d",
                             $time, res_index, exp_word[58:47]);
                    errors++;
                end
                if (res_len !== exp_word[46:36]) begin
                    $display("Error at %0t: length %0d, expected %0d",
                             $time, res_len, exp_word[46:36]);
                    errors++;
                end
                if (res_sum !== exp_word[35:12]) begin
                    $display("Error at %0t: sum %0d, expected %0d",
                             $time, res_sum, exp_word[35:12]);
                    errors++;
                end
                if (res_max !== exp_word[11:0]) begin
                    $display("Error at %0t: max %0d, expected %0d",
                             $time, res_max, exp_word[11:0]);
                    errors++;
                end
            end
        end
    end

    // twice the driven cycles of all phases
    initial begin : watchdog
        int cycles;
        cycles = 2 * frame_cycles(8, 6) + frame_cycles(8, 2) + frame_cycles(1, 2)
               + frame_cycles(33, 2) + frame_cycles(8, 6) + frame_cycles(40, 3);
        #(2 * cycles * 40);
        $display("timeout, the run did not finish within %0d clock cycles", 2 * cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin : main
        int widths [3];
        widths     = '{8, 1, 33};
        img_dclk   = 1'b0;
        rst_n      = 1'b0;
        img_fv     = 1'b0;
        img_lv     = 1'b0;
        img_d      = '0;
        res_ready  = 1'b0;
        lfsr       = 17'd91716;
        strict     = 1'b1;
        cur_width  = 11'd8;
        ready_mode = 0;
        stall_cnt  = 0;
        errors     = 0;
        results    = 0;
        repeat (4) @(posedge img_dclk);
        rst_n <= 1'b1;

        // contents and index over two 8x6 frames
        send_frame(8, 6);
        send_frame(8, 6);
        drain_expected();

        // odd widths with two lines each
        foreach (widths[i]) begin
            send_frame(widths[i], 2);
            drain_expected();
            if (overflow !== 1'b0 || drop_count !== 16'd0) begin
                $display("Error at %0t: width %0d, overflow %0b drops %0d, expected none",
                         $time, widths[i], overflow, drop_count);
                errors++;
            end
        end

        // each result stalled 4 cycles
        ready_mode <= 1;
        send_frame(8, 6);
        drain_expected();
        if (overflow !== 1'b0 || drop_count !== 16'd0) begin
            $display("Error at %0t: short stalls gave overflow %0b drops %0d, expected none",
                     $time, overflow, drop_count);
            errors++;
        end

        // ready low through the second 40-pixel line so the fifo fills
        ready_mode <= 2;
        strict     <= 1'b0;
        cur_width  <= 11'd40;
        fork
            send_frame(40, 3);
            begin
                // third line has started and lost its first pixels
                repeat (105) @(posedge img_dclk);
                ready_mode <= 0;
            end
        join
        wait_results_idle();
        if (overflow !== 1'b1) begin
            $display("the overflow flag stayed low although the fifo was held full");
            errors++;
        end
        if (drop_count == 16'd0) begin
            $display("the drop count stayed at zero although the fifo was held full");
            errors++;
        end

        $display("summary: %0d errors, %0d results accepted", errors, results);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== design/capture_cfg.svh ====
`ifndef CAPTURE_CFG_SVH
`define CAPTURE_CFG_SVH

// sensor pixel width
`define CAP_PIX_W 12

// pixels per line counter width, lines up to 2047 pixels
`define CAP_LEN_W 11

// fifo entries, also the producer's starting credit count
`define CAP_FIFO_DEPTH 16

// per-line pixel sum, wide enough for 2047 pixels of 4095
`define CAP_SUM_W 24

// line index within a frame
`define CAP_IDX_W 12

`endif

// ==== design/capture_pkg.sv ====
`include "capture_cfg.svh"

package capture_pkg;

    // what an fifo entry stands for
    typedef enum logic [1:0] {
        kind_pixel       = 2'd0,
        kind_frame_start = 2'd1,
        kind_line_end    = 2'd2
    } entry_kind_e;

    // line_end marker payload
    typedef struct packed {
        // set on the first line after frame start
        logic                  first_line;
        // pixels actually sent for the line, drops excluded
        logic [`CAP_LEN_W-1:0] line_len;
    } marker_t;

    // one payload word, read according to the entry kind
    typedef union packed {
        logic [`CAP_PIX_W-1:0] pix_value;
        marker_t               marker;
    } entry_payload_u;

    // 14-bit entry on the link and in the fifo
    typedef struct packed {
        entry_kind_e    kind;
        entry_payload_u payload;
    } pix_entry_t;

endpackage

// ==== design/capture_top.sv ====
`timescale 1ns/1ps

`include "capture_cfg.svh"

module capture_top import capture_pkg::*; (
    input  logic                  img_dclk,
    input  logic                  rst_n,
    input  logic                  img_fv,
    input  logic                  img_lv,
    input  logic [`CAP_PIX_W-1:0] img_d,
    output logic                  res_valid,
    input  logic                  res_ready,
    output logic [`CAP_IDX_W-1:0] res_index,
    output logic [`CAP_LEN_W-1:0] res_len,
    output logic [`CAP_SUM_W-1:0] res_sum,
    output logic [`CAP_PIX_W-1:0] res_max,
    output logic                  overflow,
    output logic [15:0]           drop_count
);

    // producer to fifo
    pix_credit_if link ();

    // fifo head to consumer
    logic       head_valid;
    pix_entry_t head;
    logic       pop;

    sensor_capture u_capture (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .img_fv     (img_fv),
        .img_lv     (img_lv),
        .img_d      (img_d),
        .link       (link.producer),
        .overflow   (overflow),
        .drop_count (drop_count)
    );

    pixel_fifo u_fifo (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .link       (link.buffer),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop)
    );

    line_stats u_stats (
        .img_dclk   (img_dclk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .res_index  (res_index),
        .res_len    (res_len),
        .res_sum    (res_sum),
        .res_max    (res_max)
    );

endmodule

// ==== design/line_stats.sv ====
`timescale 1ns/1ps

`include "capture_cfg.svh"

module line_stats import capture_pkg::*; (
    input  logic                  img_dclk,
    input  logic                  rst_n,
    input  logic                  head_valid,
    input  pix_entry_t            head,
    output logic                  pop,
    output logic                  res_valid,
    input  logic                  res_ready,
    output logic [`CAP_IDX_W-1:0] res_index,
    output logic [`CAP_LEN_W-1:0] res_len,
    output logic [`CAP_SUM_W-1:0] res_sum,
    output logic [`CAP_PIX_W-1:0] res_max
);

    // running line accumulators
    logic [`CAP_SUM_W-1:0] acc_sum;
    logic [`CAP_PIX_W-1:0] acc_max;
    // index of the line being accumulated
    logic [`CAP_IDX_W-1:0] line_idx;

    logic                  res_full;
    logic [`CAP_PIX_W-1:0] pix;
    marker_t               mark;

    // result held and not taken this cycle
    assign res_full = res_valid && !res_ready;
    assign pop      = head_valid && !res_full;

    // two readings of the same payload word
    assign pix  = head.payload.pix_value;
    assign mark = head.payload.marker;

    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            acc_sum   <= '0;
            acc_max   <= '0;
            line_idx  <= '0;
            res_valid <= 1'b0;
        end else begin
            // taken by downstream
            if (res_valid && res_ready) begin
                res_valid <= 1'b0;
            end

            if (pop) begin
                case (head.kind)
                    kind_pixel: begin
                        acc_sum <= acc_sum + `CAP_SUM_W'(pix);
                        if (pix > acc_max) begin
                            acc_max <= pix;
                        end
                    end
                    kind_frame_start: begin
                        // drop any partial line from before
                        line_idx <= '0;
                        acc_sum  <= '0;
                        acc_max  <= '0;
                    end
                    kind_line_end: begin
                        res_valid <= 1'b1;
                        acc_sum   <= '0;
                        acc_max   <= '0;
                        // first-line flag covers a lost frame_start
                        if (mark.first_line) begin
                            line_idx <= `CAP_IDX_W'(1);
                        end else begin
                            line_idx <= line_idx + 1'b1;
                        end
                    end
                    default: begin
                        acc_sum <= acc_sum;
                    end
                endcase
            end
        end
    end

    // result payload loaded on a popped line end
    always_ff @(posedge img_dclk) begin
        if (pop && head.kind == kind_line_end) begin
            res_index <= mark.first_line ? '0 : line_idx;
            res_len   <= mark.line_len;
            res_sum   <= acc_sum;
            res_max   <= acc_max;
        end
    end

    // a stalled result stays valid and unchanged
    a_hold_result: assert property (@(posedge img_dclk) disable iff (!rst_n)
        res_full |=> (res_valid && $stable({res_index, res_len, res_sum, res_max})));

endmodule

// ==== design/pix_credit_if.sv ====
`timescale 1ns/1ps

// credit-based link from sensor_capture to pixel_fifo
interface pix_credit_if import capture_pkg::*; ();

    // one entry per cycle when high
    logic       push;
    // entry carried with push
    pix_entry_t entry;
    // one-cycle pulse for each freed fifo slot
    logic       credit;

    // producer side
    modport producer (
        output push,
        output entry,
        input  credit
    );

    // fifo side
    modport buffer (
        input  push,
        input  entry,
        output credit
    );

endinterface

// ==== design/pixel_fifo.sv ====
`timescale 1ns/1ps

`include "capture_cfg.svh"

module pixel_fifo import capture_pkg::*; (
    input  logic         img_dclk,
    input  logic         rst_n,
    pix_credit_if.buffer link,
    output logic         head_valid,
    output pix_entry_t   head,
    input  logic         pop
);

    localparam int PTR_W = $clog2(`CAP_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`CAP_FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`CAP_FIFO_DEPTH - 1);

    // entry storage
    pix_entry_t        mem [`CAP_FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    // occupancy
    logic [CNT_W-1:0]  count;

    // head straight from the array, valid once count is updated
    assign head_valid = count != '0;
    assign head       = mem[rd_ptr];

    // storage write, no reset
    always_ff @(posedge img_dclk) begin
        if (link.push) begin
            mem[wr_ptr] <= link.entry;
        end
    end

    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            link.credit <= 1'b0;
        end else begin
            // freed slot goes back to the producer next cycle
            link.credit <= pop;

            // pointers wrap by compare, depth need not be a power of two
            if (link.push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end

            case ({link.push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // producer credit count keeps the fifo from overflowing
    a_no_push_full: assert property (@(posedge img_dclk) disable iff (!rst_n)
        link.push |-> count != CNT_W'(`CAP_FIFO_DEPTH));

    // consumer only pops a valid head
    a_no_pop_empty: assert property (@(posedge img_dclk) disable iff (!rst_n)
        pop |-> count != '0);

endmodule

// ==== design/sensor_capture.sv ====
`timescale 1ns/1ps

`include "capture_cfg.svh"

module sensor_capture import capture_pkg::*; (
    input  logic                  img_dclk,
    input  logic                  rst_n,
    input  logic                  img_fv,
    input  logic                  img_lv,
    input  logic [`CAP_PIX_W-1:0] img_d,
    pix_credit_if.producer        link,
    output logic                  overflow,
    output logic [15:0]           drop_count
);

    localparam int CRED_W = $clog2(`CAP_FIFO_DEPTH + 1);

    // previous fv/lv for edge detection
    logic                  fv_q;
    logic                  lv_q;
    // pixels pushed so far in the current line
    logic [`CAP_LEN_W-1:0] pix_cnt;
    logic                  first_line;
    logic [CRED_W-1:0]     credits;

    logic       frame_rise;
    logic       line_fall;
    logic       pix_sample;
    logic       want;
    logic       spend;
    pix_entry_t nxt_entry;

    always_comb begin
        frame_rise = img_fv && !fv_q;
        // line end only counts inside a frame
        line_fall  = img_fv && lv_q && !img_lv;
        pix_sample = img_fv && img_lv;
        want       = frame_rise || line_fall || pix_sample;
        // markers need a credit like pixels
        spend      = want && (credits != '0);

        nxt_entry = '0;
        // frame start wins over a pixel in the same sample
        if (frame_rise) begin
            nxt_entry.kind = kind_frame_start;
        end else if (line_fall) begin
            nxt_entry.kind                      = kind_line_end;
            nxt_entry.payload.marker.first_line = first_line;
            nxt_entry.payload.marker.line_len   = pix_cnt;
        end else begin
            nxt_entry.kind              = kind_pixel;
            nxt_entry.payload.pix_value = img_d;
        end
    end

    always_ff @(posedge img_dclk) begin
        if (!rst_n) begin
            fv_q       <= 1'b0;
            lv_q       <= 1'b0;
            pix_cnt    <= '0;
            first_line <= 1'b0;
            credits    <= CRED_W'(`CAP_FIFO_DEPTH);
            link.push  <= 1'b0;
            overflow   <= 1'b0;
            drop_count <= '0;
        end else begin
            fv_q      <= img_fv;
            lv_q      <= img_lv;
            link.push <= spend;
            // one back per credit pulse and one spent per push
            credits   <= credits + CRED_W'(link.credit) - CRED_W'(spend);

            // entry lost for lack of credit
            if (want && !spend) begin
                overflow <= 1'b1;
                // saturate
                if (drop_count != '1) begin
                    drop_count <= drop_count + 16'd1;
                end
            end

            if (frame_rise) begin
                first_line <= 1'b1;
            end else if (line_fall) begin
                first_line <= 1'b0;
            end

            if (frame_rise || line_fall) begin
                pix_cnt <= '0;
            end else if (pix_sample && spend) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // entry payload that push qualifies
    always_ff @(posedge img_dclk) begin
        if (want) begin
            link.entry <= nxt_entry;
        end
    end

    // returned credits never outnumber fifo slots
    a_credit_bound: assert property (@(posedge img_dclk) disable iff (!rst_n)
        credits <= CRED_W'(`CAP_FIFO_DEPTH));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the log contents

rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_capture \
    -Mdir obj_dir -o tb_capture_sim > build.log 2>&1 \
    && ./obj_dir/tb_capture_sim > sim.log 2>&1 \
    || { echo "build or run failed, see build.log and sim.log"; cat build.log; }

grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== vlog.f ====
+incdir+design
design/capture_pkg.sv
design/pix_credit_if.sv
design/sensor_capture.sv
design/pixel_fifo.sv
design/line_stats.sv
design/capture_top.sv
bench/tb_capture.sv
